/* compile.f */
logic/core_pkg.sv
logic/decoder.sv
logic/alu.sv
logic/reg_file.sv
logic/data_mem.sv
logic/branch_unit.sv
logic/core_top.sv
testbench/clock_gen.sv
testbench/core_props.sv
testbench/core_tb.sv

/* run.sh */
#!/bin/sh
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module core_tb -f compile.f -o core_tb_sim \
  > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/core_tb_sim > sim.log 2>&1
cat sim.log
! grep -q '>>> FAIL' sim.log && grep -q '>>> PASS' sim.log && exit 0 || exit 1

/* testbench/core_tb.sv */
// core testbench: random RV32I stream, ISA reference model and retire checks
`timescale 1ns/1ps

module core_tb import core_pkg::*;;

  localparam int DMEM_WORDS     = 64;
  localparam int MW             = $clog2(DMEM_WORDS);
  localparam int N_INSTR        = 2000;
  localparam int TIMEOUT_CYCLES = 4 * N_INSTR + 100;

  logic    clk;
  logic    rst_n;
  logic    instr_valid;
  word     instr;
  word     instr_pc;
  logic    instr_ready;
  word     fetch_pc;
  logic    retire_valid;
  retire_t retire;
  logic    retire_ready;

  word     lcg_state = 32'he1e6_badd;
  word     regs_model [32];
  word     mem_model [DMEM_WORDS];
  retire_t expected [$];
  word     model_pc = '0;
  logic    slot_full = 1'b0;
  int      issued = 0;
  int      consumed = 0;
  int      cycles = 0;

  clock_gen u_clock_gen (
    .clk  (clk),
    .rst_n(rst_n)
  );

  core_top #(
    .DMEM_WORDS(DMEM_WORDS)
  ) dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .instr_pc    (instr_pc),
    .instr_ready (instr_ready),
    .fetch_pc    (fetch_pc),
    .retire_valid(retire_valid),
    .retire      (retire),
    .retire_ready(retire_ready)
  );

  initial begin
    instr_valid  <= 1'b0;
    instr        <= '0;
    instr_pc     <= '0;
    retire_ready <= 1'b0;
    for (int i = 0; i < 32; i++) begin
      regs_model[i] = '0;
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
      mem_model[i] = '0;
    end
  end

  function automatic word lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // registers limited to x0..x7 so results feed each other
  function automatic word random_instr();
    word        rnd;
    word        kind;
    word        ins;
    r           rd;
    r           rs1;
    r           rs2;
    logic [2:0] f3;
    logic       alt;
    rnd  = lcg_next();
    kind = lcg_next() % 32'd10;
    rd   = {2'b0, rnd[2:0]};
    rs1  = {2'b0, rnd[5:3]};
    rs2  = {2'b0, rnd[8:6]};
    f3   = rnd[11:9];
    alt  = rnd[17] && ((f3 == 3'b000) || (f3 == 3'b101));
    case (kind)
      0: begin
        if (f3 == 3'b001) begin
          ins = {7'b0, rnd[16:12], rs1, f3, rd, 7'b0010011};
        end else if (f3 == 3'b101) begin
          ins = {1'b0, rnd[17], 5'b0, rnd[16:12], rs1, f3, rd, 7'b0010011};
        end else begin
          ins = {rnd[31:20], rs1, f3, rd, 7'b0010011};
        end
      end
      1: ins = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
      2: ins = {rnd[31:12], rd, 7'b0110111};
      3: ins = {rnd[31:12], rd, 7'b0010111};
      4: ins = {rnd[31:12], rd, 7'b1101111};
      5: ins = {rnd[31:20], rs1, 3'b000, rd, 7'b1100111};
      6: begin
        // funct3 010 and 011 are not branches, fold them onto beq/bne
        if (f3[2:1] == 2'b01) begin
          f3 = {2'b00, f3[0]};
        end
        ins = {rnd[31:25], rs2, rs1, f3, rnd[16:12], 7'b1100011};
      end
      7: ins = {rnd[31:20], rs1, 3'b010, rd, 7'b0000011};
      8: ins = {rnd[31:25], rs2, rs1, 3'b010, rnd[16:12], 7'b0100011};
      default: begin
        // fence, csr or an opcode the core does not know
        if (rnd[13:12] == 2'b00) begin
          ins = 32'h0ff0_000f;
        end else if (rnd[13:12] == 2'b01) begin
          ins = {rnd[31:7], 7'b1110011};
        end else begin
          ins = {rnd[31:7], 7'b1011011};
        end
      end
    endcase
    return ins;
  endfunction

  function automatic word alu_expect(logic [2:0] f3, logic alt, word a, word b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  return (a < b) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b101:  return alt ? word'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_holds(logic [2:0] f3, word a, word b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      3'b111:  return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // executes one instruction on the register and memory models
  function automatic retire_t reference_step(word ins, word pc);
    retire_t rec;
    word     a;
    word     b;
    word     imm_i;
    word     imm_s;
    word     imm_b;
    word     imm_j;
    word     val;
    word     idx;
    logic    wr;
    a     = regs_model[ins[19:15]];
    b     = regs_model[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    rec.pc       = pc;
    rec.next_pc  = pc + 32'd4;
    rec.rd       = '0;
    rec.wb_value = '0;
    wr  = 1'b0;
    val = '0;
    case (ins[6:0])
      7'b0110111: begin
        wr  = 1'b1;
        val = {ins[31:12], 12'b0};
      end
      7'b0010111: begin
        wr  = 1'b1;
        val = pc + {ins[31:12], 12'b0};
      end
      7'b1101111: begin
        wr          = 1'b1;
        val         = pc + 32'd4;
        rec.next_pc = pc + imm_j;
      end
      7'b1100111: begin
        wr          = 1'b1;
        val         = pc + 32'd4;
        rec.next_pc = (a + imm_i) & 32'hffff_fffe;
      end
      7'b1100011: begin
        if (branch_holds(ins[14:12], a, b)) begin
          rec.next_pc = pc + imm_b;
        end
      end
      7'b0000011: begin
        idx = ((a + imm_i) >> 2) % DMEM_WORDS;
        wr  = 1'b1;
        val = mem_model[idx[MW-1:0]];
      end
      7'b0100011: begin
        idx = ((a + imm_s) >> 2) % DMEM_WORDS;
        mem_model[idx[MW-1:0]] = b;
      end
      7'b0010011: begin
        wr  = 1'b1;
        val = alu_expect(ins[14:12], ins[30] && (ins[14:12] == 3'b101), a, imm_i);
      end
      7'b0110011: begin
        wr  = 1'b1;
        val = alu_expect(ins[14:12], ins[30], a, b);
      end
      default: begin
      end
    endcase
    if (wr && (ins[11:7] != '0)) begin
      rec.rd                 = ins[11:7];
      rec.wb_value           = val;
      regs_model[ins[11:7]] = val;
    end
    return rec;
  endfunction

  task automatic abort_run();
    $display(">>> FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic compare_retire(retire_t got, retire_t exp);
    if (got !== exp) begin
      $display("** Error @ %0t: got pc %h npc %h rd %0d wb %h, exp pc %h npc %h rd %0d wb %h",
               $time, got.pc, got.next_pc, got.rd, got.wb_value,
               exp.pc, exp.next_pc, exp.rd, exp.wb_value);
      abort_run();
    end
  endtask

  task automatic compare_word(string what, word got, word exp);
    if (got !== exp) begin
      $display("** Error @ %0t: %s is %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic compare_flag(string what, logic got, logic exp);
    if (got !== exp) begin
      $display("** Error @ %0t: %s is %b, expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  // fetch driver, reference model and consumer back-pressure
  always @(posedge clk) begin
    retire_t rec;
    logic    accept;
    if (rst_n) begin
      compare_word("fetch_pc", fetch_pc, model_pc);
      // single retire slot model
      compare_flag("retire_valid", retire_valid, slot_full);
      compare_flag("instr_ready", instr_ready, !slot_full || retire_ready);
      accept = instr_valid && instr_ready;
      if (accept) begin
        rec = reference_step(instr, instr_pc);
        expected.push_back(rec);
        model_pc = rec.next_pc;
      end
      slot_full = accept || (slot_full && !retire_ready);
      if (!instr_valid || instr_ready) begin
        if ((issued < N_INSTR) && ((lcg_next() % 32'd4) != 32'd0)) begin
          instr_valid <= 1'b1;
          instr       <= random_instr();
          instr_pc    <= model_pc;
          issued++;
        end else begin
          instr_valid <= 1'b0;
        end
      end
      retire_ready <= (lcg_next() % 32'd4) != 32'd0;
    end
  end

  always @(posedge clk) begin
    if (rst_n && retire_valid && retire_ready) begin
      if (expected.size() == 0) begin
        $display("a record retired with no accepted instruction left to match it");
        abort_run();
      end else begin
        compare_retire(retire, expected.pop_front());
        consumed++;
        if (consumed == N_INSTR) begin
          if (expected.size() == 0) begin
            $display(">>> PASS");
            $finish;
          end else begin
            $display("%0d accepted instructions never retired", expected.size());
            abort_run();
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: %0d of %0d records retired after %0d cycles",
               consumed, N_INSTR, cycles);
      abort_run();
    end
  end

endmodule

/* testbench/core_props.sv */
// core assertions: stall stability on both streams and retire state in reset
`timescale 1ns/1ps

module core_props import core_pkg::*; (
  input logic    clk,
  input logic    rst_n,
  input logic    instr_valid,
  input word     instr,
  input word     instr_pc,
  input logic    instr_ready,
  input logic    retire_valid,
  input retire_t retire,
  input logic    retire_ready
);

  // producer holds the fetch bus until it is taken
  fetch_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (instr_valid && !instr_ready) |=> (instr_valid && $stable(instr) && $stable(instr_pc)))
    else $error("fetch inputs changed while the core was stalled");

  retire_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (retire_valid && !retire_ready) |=> (retire_valid && $stable(retire)))
    else $error("retire record changed while the consumer was stalled");

  reset_idle: assert property (@(posedge clk) !rst_n |=> !retire_valid)
    else $error("retire_valid high during reset");

endmodule

bind core_top core_props u_core_props (
  .clk         (clk),
  .rst_n       (rst_n),
  .instr_valid (instr_valid),
  .instr       (instr),
  .instr_pc    (instr_pc),
  .instr_ready (instr_ready),
  .retire_valid(retire_valid),
  .retire      (retire),
  .retire_ready(retire_ready)
);

/* testbench/clock_gen.sv */
// clock and reset source for the core testbench, 4 ns period
`timescale 1ns/1ps

module clock_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // held low over the first three rising edges
  initial begin
    rst_n <= 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

/* logic/core_top.sv */
// single-issue RV32I core with fetch and retire valid/ready streams
`timescale 1ns/1ps

module core_top import core_pkg::*; #(
  parameter int DMEM_WORDS = 256
) (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    instr_valid,
  input  word     instr,
  input  word     instr_pc,
  output logic    instr_ready,
  output word     fetch_pc,
  output logic    retire_valid,
  output retire_t retire,
  input  logic    retire_ready
);

  pc_mux_t      pc_mux_sel;
  wb_data_mux_t wb_data_mux_sel;
  r             wb_r;
  logic         wb_write_enable;
  alu_a_mux_t   alu_a_mux_sel;
  alu_b_mux_t   alu_b_mux_sel;
  alu_op_t      alu_op;
  logic         sub_arith;
  word          imm;
  r             rs1;
  r             rs2;
  branch_t      branch_cond;
  logic         dmem_write_enable;

  word  rs1_data;
  word  rs2_data;
  word  alu_a;
  word  alu_b;
  word  alu_result;
  word  mem_rdata;
  word  wb_data;
  word  next_pc;
  logic fire;

  // one retire slot, refilled on the edge it drains
  assign instr_ready = !retire_valid || retire_ready;
  assign fire        = instr_valid && instr_ready;

  decoder u_decoder (
    .instr            (instr),
    .pc_mux_sel       (pc_mux_sel),
    .wb_data_mux_sel  (wb_data_mux_sel),
    .wb_r             (wb_r),
    .wb_write_enable  (wb_write_enable),
    .alu_a_mux_sel    (alu_a_mux_sel),
    .alu_b_mux_sel    (alu_b_mux_sel),
    .alu_op           (alu_op),
    .sub_arith        (sub_arith),
    .imm              (imm),
    .rs1              (rs1),
    .rs2              (rs2),
    .branch_cond      (branch_cond),
    .dmem_write_enable(dmem_write_enable)
  );

  reg_file u_reg_file (
    .clk         (clk),
    .rst_n       (rst_n),
    .rs1         (rs1),
    .rs2         (rs2),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .write_enable(fire && wb_write_enable),
    .wb_r        (wb_r),
    .wb_data     (wb_data)
  );

  assign alu_a = (alu_a_mux_sel == PC) ? instr_pc : rs1_data;
  assign alu_b = (alu_b_mux_sel == IMM) ? imm : rs2_data;

  alu u_alu (
    .a        (alu_a),
    .b        (alu_b),
    .op       (alu_op),
    .sub_arith(sub_arith),
    .result   (alu_result)
  );

  data_mem #(
    .DMEM_WORDS(DMEM_WORDS)
  ) u_data_mem (
    .clk         (clk),
    .addr        (alu_result),
    .write_data  (rs2_data),
    .write_enable(fire && dmem_write_enable),
    .read_data   (mem_rdata)
  );

  branch_unit u_branch_unit (
    .pc         (instr_pc),
    .imm        (imm),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .alu_result (alu_result),
    .pc_mux_sel (pc_mux_sel),
    .branch_cond(branch_cond),
    .next_pc    (next_pc)
  );

  always_comb begin
    case (wb_data_mux_sel)
      MEM:     wb_data = mem_rdata;
      PC4:     wb_data = instr_pc + 32'd4;
      default: wb_data = alu_result;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fetch_pc     <= '0;
      retire_valid <= 1'b0;
    end else if (fire) begin
      fetch_pc     <= next_pc;
      retire_valid <= 1'b1;
    end else if (retire_ready) begin
      retire_valid <= 1'b0;
    end
  end

  // record payload, held while the consumer stalls
  always_ff @(posedge clk) begin
    if (fire) begin
      retire.pc       <= instr_pc;
      retire.next_pc  <= next_pc;
      retire.rd       <= wb_write_enable ? wb_r : '0;
      retire.wb_value <= (wb_write_enable && (wb_r != '0)) ? wb_data : '0;
    end
  end

endmodule

/* logic/branch_unit.sv */
// branch unit: condition check and next pc selection
`timescale 1ns/1ps

module branch_unit import core_pkg::*; (
  input  word     pc,
  input  word     imm,
  input  word     rs1_data,
  input  word     rs2_data,
  input  word     alu_result,
  input  pc_mux_t pc_mux_sel,
  input  branch_t branch_cond,
  output word     next_pc
);

  logic taken;
  word  pc_plus4;
  word  pc_target;

  assign pc_plus4  = pc + 32'd4;
  assign pc_target = pc + imm;

  always_comb begin
    case (branch_cond)
      BEQ:     taken = rs1_data == rs2_data;
      BNE:     taken = rs1_data != rs2_data;
      BLT:     taken = $signed(rs1_data) < $signed(rs2_data);
      BGE:     taken = $signed(rs1_data) >= $signed(rs2_data);
      BLTU:    taken = rs1_data < rs2_data;
      BGEU:    taken = rs1_data >= rs2_data;
      // funct3 010/011 are not branches
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    case (pc_mux_sel)
      PC_BRANCH: next_pc = taken ? pc_target : pc_plus4;
      PC_JAL:    next_pc = pc_target;
      PC_JALR:   next_pc = {alu_result[31:1], 1'b0};
      default:   next_pc = pc_plus4;
    endcase
  end

endmodule

/* logic/data_mem.sv */
// data memory: word addressed, async read, sync write, wraps on its depth
`timescale 1ns/1ps

module data_mem import core_pkg::*; #(
  parameter int DMEM_WORDS = 256
) (
  input  logic clk,
  input  word  addr,
  input  word  write_data,
  input  logic write_enable,
  output word  read_data
);

  localparam int AW = $clog2(DMEM_WORDS);

  word          mem [DMEM_WORDS];
  logic [AW-1:0] index;

  // byte offset dropped, upper bits wrap
  assign index = addr[AW+1:2];

  initial begin
    for (int i = 0; i < DMEM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (write_enable) begin
      mem[index] <= write_data;
    end
  end

  assign read_data = mem[index];

endmodule

/* logic/reg_file.sv */
// register file: 32 x 32 bit, two async read ports, one write port, x0 fixed
`timescale 1ns/1ps

module reg_file import core_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  r     rs1,
  input  r     rs2,
  output word  rs1_data,
  output word  rs2_data,
  input  logic write_enable,
  input  r     wb_r,
  input  word  wb_data
);

  word regs [32];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (write_enable && (wb_r != '0)) begin
      regs[wb_r] <= wb_data;
    end
  end

  // old value visible in the write cycle
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* logic/alu.sv */
// alu: add/sub, shifts, compares, logic ops and operand pass-through
`timescale 1ns/1ps

module alu import core_pkg::*; (
  input  word     a,
  input  word     b,
  input  alu_op_t op,
  input  logic    sub_arith,
  output word     result
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      ADD:    result = sub_arith ? a - b : a + b;
      SLL:    result = a << shamt;
      SLT:    result = {31'b0, $signed(a) < $signed(b)};
      SLTU:   result = {31'b0, a < b};
      XOR:    result = a ^ b;
      SR: begin
        if (sub_arith) begin
          result = $signed(a) >>> shamt;
        end else begin
          result = a >> shamt;
        end
      end
      OR:     result = a | b;
      AND:    result = a & b;
      // lui
      PASS_B: result = b;
      default: result = '0;
    endcase
  end

endmodule

/* logic/decoder.sv */
// instruction decoder: RV32I field split, immediates and datapath control
`timescale 1ns/1ps

module decoder import core_pkg::*; (
  input  word          instr,
  output pc_mux_t      pc_mux_sel,
  output wb_data_mux_t wb_data_mux_sel,
  output r             wb_r,
  output logic         wb_write_enable,
  output alu_a_mux_t   alu_a_mux_sel,
  output alu_b_mux_t   alu_b_mux_sel,
  output alu_op_t      alu_op,
  output logic         sub_arith,
  output word          imm,
  output r             rs1,
  output r             rs2,
  output branch_t      branch_cond,
  output logic         dmem_write_enable
);

  // base opcode map
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_ALUI   = 7'b0010011,
    OP_ALU    = 7'b0110011,
    OP_FENCE  = 7'b0001111,
    OP_CSR    = 7'b1110011
  } op_t;

  logic [6:0] opcode;
  logic [2:0] funct3;
  word        imm_i;
  word        imm_s;
  word        imm_b;
  word        imm_u;
  word        imm_j;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign wb_r   = instr[11:7];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    // no-op unless an opcode below says otherwise
    pc_mux_sel        = PC_PLUS4;
    wb_data_mux_sel   = ALU;
    wb_write_enable   = 1'b0;
    alu_a_mux_sel     = RS1;
    alu_b_mux_sel     = RS2;
    alu_op            = ADD;
    sub_arith         = 1'b0;
    imm               = imm_i;
    branch_cond       = branch_t'(funct3);
    dmem_write_enable = 1'b0;

    case (opcode)
      OP_LUI: begin
        imm             = imm_u;
        alu_b_mux_sel   = IMM;
        alu_op          = PASS_B;
        wb_write_enable = 1'b1;
      end
      OP_AUIPC: begin
        imm             = imm_u;
        alu_a_mux_sel   = PC;
        alu_b_mux_sel   = IMM;
        wb_write_enable = 1'b1;
      end
      OP_JAL: begin
        imm             = imm_j;
        pc_mux_sel      = PC_JAL;
        wb_data_mux_sel = PC4;
        wb_write_enable = 1'b1;
      end
      OP_JALR: begin
        // target comes out of the alu as rs1 + imm
        alu_b_mux_sel   = IMM;
        pc_mux_sel      = PC_JALR;
        wb_data_mux_sel = PC4;
        wb_write_enable = 1'b1;
      end
      OP_BRANCH: begin
        imm        = imm_b;
        pc_mux_sel = PC_BRANCH;
      end
      OP_LOAD: begin
        // LW only, other widths fall through as no-ops
        if (funct3 == 3'b010) begin
          alu_b_mux_sel   = IMM;
          wb_data_mux_sel = MEM;
          wb_write_enable = 1'b1;
        end
      end
      OP_STORE: begin
        imm = imm_s;
        if (funct3 == 3'b010) begin
          alu_b_mux_sel     = IMM;
          dmem_write_enable = 1'b1;
        end
      end
      OP_ALUI: begin
        alu_b_mux_sel   = IMM;
        alu_op          = alu_op_t'({1'b0, funct3});
        // SRAI only, addi has no subtract form
        sub_arith       = (funct3 == 3'b101) && instr[30];
        wb_write_enable = 1'b1;
      end
      OP_ALU: begin
        alu_op          = alu_op_t'({1'b0, funct3});
        sub_arith       = instr[30] && ((funct3 == 3'b000) || (funct3 == 3'b101));
        wb_write_enable = 1'b1;
      end
      OP_FENCE, OP_CSR: begin
        // retire as no-op
      end
      default: begin
      end
    endcase
  end

endmodule

/* logic/core_pkg.sv */
// core package: shared word types, datapath select enums and retire record
package core_pkg;

  typedef logic [31:0] word;
  typedef logic [4:0] r;

  // next pc source
  typedef enum logic [1:0] {
    PC_PLUS4,
    PC_BRANCH,
    PC_JAL,
    PC_JALR
  } pc_mux_t;

  typedef enum logic [1:0] {
    ALU,
    MEM,
    PC4
  } wb_data_mux_t;

  typedef enum logic {
    RS1,
    PC
  } alu_a_mux_t;

  typedef enum logic {
    RS2,
    IMM
  } alu_b_mux_t;

  // low eight codes line up with funct3
  typedef enum logic [3:0] {
    ADD    = 4'd0,
    SLL    = 4'd1,
    SLT    = 4'd2,
    SLTU   = 4'd3,
    XOR    = 4'd4,
    SR     = 4'd5,
    OR     = 4'd6,
    AND    = 4'd7,
    PASS_B = 4'd8
  } alu_op_t;

  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_t;

  typedef struct packed {
    word pc;
    word next_pc;
    r    rd;
    word wb_value;
  } retire_t;

endpackage
